//--- design/csi2_csr_pkg.sv
package csi2_csr_pkg;

  localparam logic [7:0] ADDR_CTRL      = 8'h00; // bit 0 is the core enable.
  localparam logic [7:0] ADDR_CNT_SHORT = 8'h04;
  localparam logic [7:0] ADDR_CNT_LONG  = 8'h08;
  localparam logic [7:0] ADDR_CNT_FIXED = 8'h0C;
  localparam logic [7:0] ADDR_CNT_FATAL = 8'h10;

  localparam int CNT_W = 16;

  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic short_pkt;
    logic long_pkt;
    logic ecc_fixed;
    logic ecc_fatal;
  } rx_event_t;

endpackage

//--- design/csi2_header_ecc.sv
`timescale 1ns/1ps

module csi2_header_ecc
  import csi2_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] data_i,
  input  logic        valid_i,
  output csi2_word_t  word_o,
  output logic        ecc_fixed_o,
  output logic        ecc_fatal_o
);

  logic        valid_d1;
  logic        sop;
  logic [5:0]  syndrome;
  logic [31:0] fixed_data;
  logic        fix_hit;
  logic        fatal;
  logic [31:0] data_q;
  logic        valid_q;
  logic        sop_q;
  logic        err_q;

  assign sop = valid_i && !valid_d1; // first word after a gap is the header.

  always_comb
  begin
    syndrome = data_i[29:24];
    for (int i = 0; i < 24; i++)
      if (data_i[i])
        syndrome = syndrome ^ ECC_COL[i];
  end

  always_comb
  begin
    fixed_data = data_i;
    fix_hit    = 1'b0;
    for (int i = 0; i < 24; i++)
      if (syndrome == ECC_COL[i])
      begin
        fixed_data[i] = ~data_i[i];
        fix_hit       = 1'b1;
      end
    // a lone syndrome bit points at the parity bit itself.
    for (int j = 0; j < 6; j++)
      if (syndrome == 6'(1 << j))
      begin
        fixed_data[24 + j] = ~data_i[24 + j];
        fix_hit            = 1'b1;
      end
  end

  assign fatal = (syndrome != 6'd0) && !fix_hit;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      valid_d1    <= 1'b0;
      valid_q     <= 1'b0;
      sop_q       <= 1'b0;
      err_q       <= 1'b0;
      ecc_fixed_o <= 1'b0;
      ecc_fatal_o <= 1'b0;
    end
    else
    begin
      valid_d1    <= valid_i;
      valid_q     <= valid_i;
      sop_q       <= sop;
      err_q       <= sop && fatal;
      ecc_fixed_o <= sop && fix_hit;
      ecc_fatal_o <= sop && fatal;
    end

  always_ff @(posedge clk_i)
    if (sop)
      data_q <= fixed_data; // payload words pass unchanged.
    else
      data_q <= data_i;

  assign word_o = '{data: data_q, valid: valid_q, sop: sop_q, hdr_err: err_q};

  // flags ride only on real words, or the framer would start on idle cycles.
  a_flags_need_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (word_o.sop || word_o.hdr_err) |-> word_o.valid);

endmodule

//--- design/csi2_packet_framer.sv
`timescale 1ns/1ps

module csi2_packet_framer
  import csi2_rx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  csi2_word_t word_i,
  input  logic       enable_i,
  output axis_pkt_t  pkt_o,
  output logic       phy_rst_o,
  output logic       short_pkt_o,
  output logic       long_pkt_o
);

  csi2_hdr_u              hdr;
  logic                   enable_q;
  logic                   disable_flag;
  logic                   pkt_running;
  logic                   header_valid;
  logic                   short_pkt;
  logic                   long_pkt;
  logic                   last_word;
  logic                   beat;
  logic [BYTE_CNT_W-1:0]  byte_cnt;
  logic [BYTE_CNT_W-1:0]  byte_cnt_nxt;
  logic [3:0]             strb_nxt;
  logic                   tvalid_q;
  logic                   tlast_q;
  logic [31:0]            tdata_q;
  logic [3:0]             tstrb_q;

  assign hdr = word_i.data;

  assign header_valid = word_i.valid && word_i.sop && !word_i.hdr_err &&
                        !pkt_running && !disable_flag;
  assign long_pkt     = header_valid && (hdr.long_hdr.data_id.dt >= 6'(DT_LONG_MIN));
  assign short_pkt    = header_valid && (hdr.short_hdr.data_id.dt < 6'(DT_LONG_MIN));
  assign last_word    = pkt_running && word_i.valid &&
                        (byte_cnt <= BYTE_CNT_W'(WORD_BYTES));
  assign beat         = header_valid || (pkt_running && word_i.valid);

  assign phy_rst_o   = short_pkt || last_word || word_i.hdr_err || disable_flag;
  assign short_pkt_o = short_pkt;
  assign long_pkt_o  = long_pkt;

  always_comb
  begin
    byte_cnt_nxt = byte_cnt;
    if (long_pkt)
      byte_cnt_nxt = BYTE_CNT_W'(hdr.long_hdr.word_count) + BYTE_CNT_W'(CRC_BYTES);
    else if (pkt_running && word_i.valid)
    begin
      if (byte_cnt <= BYTE_CNT_W'(WORD_BYTES))
        byte_cnt_nxt = '0;
      else
        byte_cnt_nxt = byte_cnt - BYTE_CNT_W'(WORD_BYTES);
    end
  end

  always_comb
  begin
    strb_nxt = '1;
    if (last_word)
      for (int i = 0; i < WORD_BYTES; i++)
        strb_nxt[i] = (BYTE_CNT_W'(i) < byte_cnt); // only the bytes still owed.
  end

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      enable_q <= 1'b0;
    else
      enable_q <= enable_i;

  // the core only goes quiet between packets, so a running packet completes.
  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      disable_flag <= 1'b0;
    else if (!enable_q && (last_word || (!pkt_running && !header_valid)))
      disable_flag <= 1'b1;
    else if (enable_q)
      disable_flag <= 1'b0;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      pkt_running <= 1'b0;
    else if (long_pkt)
      pkt_running <= 1'b1;
    else if (last_word || word_i.hdr_err)
      pkt_running <= 1'b0; // a broken header mid packet drops the rest.

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      byte_cnt <= '0;
    else
      byte_cnt <= byte_cnt_nxt;

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      tvalid_q <= 1'b0;
      tlast_q  <= 1'b0;
    end
    else
    begin
      tvalid_q <= beat;
      tlast_q  <= short_pkt || last_word;
    end

  always_ff @(posedge clk_i)
    if (beat)
    begin
      tdata_q <= word_i.data;
      tstrb_q <= strb_nxt;
    end

  assign pkt_o = '{tvalid: tvalid_q, tdata: tdata_q, tstrb: tstrb_q, tlast: tlast_q};

  a_tlast_in_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_o.tlast |-> pkt_o.tvalid);

  // the byte counter must never run dry before the final word.
  a_strb_not_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_o.tvalid |-> (pkt_o.tstrb != 4'b0000));

endmodule

//--- design/csi2_rx_csr.sv
`timescale 1ns/1ps

module csi2_rx_csr
  import csi2_csr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  csr_req_t    csr_i,
  input  rx_event_t   evt_i,
  output logic [31:0] csr_rdata_o,
  output logic        enable_o
);

  logic [CNT_W-1:0] cnt [4];
  logic [3:0]       evt_vec;
  logic [3:0]       clr;
  logic [31:0]      rd_mux;

  // index 0 to 3 is short, long, fixed, fatal.
  assign evt_vec = {evt_i.ecc_fatal, evt_i.ecc_fixed, evt_i.long_pkt, evt_i.short_pkt};

  assign clr[0] = csr_i.wr && (csr_i.addr == ADDR_CNT_SHORT);
  assign clr[1] = csr_i.wr && (csr_i.addr == ADDR_CNT_LONG);
  assign clr[2] = csr_i.wr && (csr_i.addr == ADDR_CNT_FIXED);
  assign clr[3] = csr_i.wr && (csr_i.addr == ADDR_CNT_FATAL);

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
      enable_o <= 1'b0;
    else if (csr_i.wr && (csr_i.addr == ADDR_CTRL))
      enable_o <= csr_i.wdata[0];

  always_ff @(posedge clk_i, posedge rst_i)
    if (rst_i)
    begin
      for (int i = 0; i < 4; i++)
        cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
        if (clr[i])
          cnt[i] <= '0; // clearing wins over an event in the same cycle.
        else if (evt_vec[i])
          cnt[i] <= cnt[i] + 1'b1;
    end

  always_comb
  begin
    case (csr_i.addr)
      ADDR_CTRL:      rd_mux = {31'd0, enable_o};
      ADDR_CNT_SHORT: rd_mux = 32'(cnt[0]);
      ADDR_CNT_LONG:  rd_mux = 32'(cnt[1]);
      ADDR_CNT_FIXED: rd_mux = 32'(cnt[2]);
      ADDR_CNT_FATAL: rd_mux = 32'(cnt[3]);
      default:        rd_mux = 32'd0;
    endcase
  end

  always_ff @(posedge clk_i)
    if (csr_i.rd)
      csr_rdata_o <= rd_mux;

  a_no_wr_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    !(csr_i.wr && csr_i.rd));

endmodule

//--- design/csi2_rx_pkg.sv
package csi2_rx_pkg;

  localparam int DT_LONG_MIN = 'h10; // data types from here on are long packets.
  localparam int CRC_BYTES   = 2;
  localparam int WORD_BYTES  = 4;
  localparam int BYTE_CNT_W  = 17; // word count plus crc bytes without overflow.

  // syndrome of a single flipped header bit, indexed by data bit 0 to 23.
  localparam logic [5:0] ECC_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  typedef struct packed {
    logic [1:0] vc;
    logic [5:0] dt;
  } data_id_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] word_count;
    data_id_t    data_id;
  } long_hdr_t;

  typedef struct packed {
    logic [7:0]  ecc;
    logic [15:0] short_data; // frame or line number.
    data_id_t    data_id;
  } short_hdr_t;

  typedef union packed {
    long_hdr_t  long_hdr;
    short_hdr_t short_hdr;
  } csi2_hdr_u;

  typedef struct packed {
    logic [31:0] data;
    logic        valid;
    logic        sop;
    logic        hdr_err; // header could not be corrected.
  } csi2_word_t;

  typedef struct packed {
    logic        tvalid;
    logic [31:0] tdata;
    logic [3:0]  tstrb;
    logic        tlast;
  } axis_pkt_t;

endpackage

//--- design/csi2_rx_top.sv
`timescale 1ns/1ps

module csi2_rx_top
  import csi2_rx_pkg::*;
  import csi2_csr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] data_i,
  input  logic        valid_i,
  input  csr_req_t    csr_i,
  output logic [31:0] csr_rdata_o,
  output axis_pkt_t   pkt_o,
  output logic        phy_rst_o
);

  csi2_word_t chk_word;
  rx_event_t  evt;
  logic       enable;

  csi2_header_ecc u_header_ecc (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .data_i      (data_i),
    .valid_i     (valid_i),
    .word_o      (chk_word),
    .ecc_fixed_o (evt.ecc_fixed),
    .ecc_fatal_o (evt.ecc_fatal)
  );

  csi2_packet_framer u_packet_framer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .word_i      (chk_word),
    .enable_i    (enable),
    .pkt_o       (pkt_o),
    .phy_rst_o   (phy_rst_o),
    .short_pkt_o (evt.short_pkt),
    .long_pkt_o  (evt.long_pkt)
  );

  csi2_rx_csr u_rx_csr (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .csr_i       (csr_i),
    .evt_i       (evt),
    .csr_rdata_o (csr_rdata_o),
    .enable_o    (enable)
  );

endmodule

//--- sim.f
design/csi2_rx_pkg.sv
design/csi2_csr_pkg.sv
design/csi2_header_ecc.sv
design/csi2_packet_framer.sv
design/csi2_rx_csr.sv
design/csi2_rx_top.sv
test/tb_clk_gen.sv
test/tb_csi2_rx.sv

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam real HALF_NS = 5.0;
  localparam int RST_CYCLES = 16;

  initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

//--- test/tb_csi2_rx.sv
`timescale 1ns/1ps

module tb_csi2_rx
  import csi2_rx_pkg::*;
  import csi2_csr_pkg::*;
();

  localparam logic [15:0] SEED = 16'd24625;
  localparam logic [15:0] LFSR_TAPS = 16'hB400;
  // about 35 packets of at most 40 cycles each, plus register traffic, with wide margin.
  localparam int WATCHDOG_NS = 200_000;

  // CSI-2 header parity table, one 6-bit column per header data bit.
  localparam logic [5:0] PARITY_COL [24] = '{
    6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
    6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
    6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
  };

  logic        clk_i;
  logic        rst_i;
  logic [31:0] data_i;
  logic        valid_i;
  csr_req_t    csr_i;
  logic [31:0] csr_rdata_o;
  axis_pkt_t   pkt_o;
  logic        phy_rst_o;

  logic [15:0] lfsr_q;
  int          err_cnt;
  int          phy_cnt;
  int          exp_short;
  int          exp_long;
  int          exp_fixed;
  int          exp_fatal;
  axis_pkt_t   got_q[$];
  axis_pkt_t   exp_q[$];

  tb_clk_gen clk_gen0 (.clk_o(clk_i), .rst_o(rst_i));

  csi2_rx_top dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .data_i      (data_i),
    .valid_i     (valid_i),
    .csr_i       (csr_i),
    .csr_rdata_o (csr_rdata_o),
    .pkt_o       (pkt_o),
    .phy_rst_o   (phy_rst_o)
  );

  always @(negedge clk_i)
    if (!rst_i)
    begin
      if (pkt_o.tvalid)
        got_q.push_back(pkt_o);
      if (phy_rst_o)
        phy_cnt++;
    end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        lsb;
    r = '0;
    for (int k = 0; k < n; k++)
    begin
      r = {r[30:0], lfsr_q[0]};
      lsb = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (lsb)
        lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    return r;
  endfunction

  function automatic logic [5:0] calc_ecc(input logic [23:0] d);
    logic [5:0] e;
    e = '0;
    for (int i = 0; i < 24; i++)
      if (d[i])
        e = e ^ PARITY_COL[i];
    return e;
  endfunction

  task automatic csr_write(input logic [7:0] addr, input logic [31:0] wdata);
    @(negedge clk_i);
    csr_i = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: wdata};
    @(negedge clk_i);
    csr_i = '0;
  endtask

  task automatic csr_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    @(negedge clk_i);
    csr_i = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'd0};
    @(negedge clk_i);
    csr_i = '0;
    if (csr_rdata_o !== exp)
    begin
      $display("ERR %s got %h exp %h", name, csr_rdata_o, exp);
      err_cnt++;
    end
  endtask

  // sends one packet and checks the beats; flip_a and flip_b are header bits to corrupt.
  task automatic frame_packet(input logic [5:0] dt, input int wc, input int flip_a,
                              input int flip_b, input bit enabled, input bit check_phy);
    logic [1:0]  vc;
    logic [23:0] body;
    logic [31:0] good;
    logic [31:0] sent;
    logic [31:0] words[$];
    int          n_words;
    int          rem;
    int          n_flips;
    bit          is_long;
    got_q.delete();
    exp_q.delete();
    phy_cnt = 0;
    is_long = (dt >= 6'(DT_LONG_MIN));
    vc = 2'(rand_bits(2));
    body = {wc[15:0], vc, dt};
    good = {2'b00, calc_ecc(body), body};
    sent = good;
    n_flips = 0;
    if (flip_a >= 0)
    begin
      sent[flip_a] = ~sent[flip_a];
      n_flips++;
    end
    if (flip_b >= 0)
    begin
      sent[flip_b] = ~sent[flip_b];
      n_flips++;
    end
    n_words = is_long ? (wc + CRC_BYTES + 3) / 4 : 0;
    for (int i = 0; i < n_words; i++)
      words.push_back(rand_bits(32));
    if (n_flips == 1)
      exp_fixed++;
    if (n_flips == 2)
      exp_fatal++;
    if (enabled && n_flips < 2)
    begin
      exp_q.push_back('{tvalid: 1'b1, tdata: good, tstrb: 4'hF, tlast: !is_long});
      rem = wc + CRC_BYTES - 4 * (n_words - 1);
      for (int i = 0; i < n_words; i++)
        exp_q.push_back('{tvalid: 1'b1, tdata: words[i],
                          tstrb: (i == n_words - 1) ? 4'((1 << rem) - 1) : 4'hF,
                          tlast: (i == n_words - 1)});
      if (is_long)
        exp_long++;
      else
        exp_short++;
    end
    @(negedge clk_i);
    data_i = sent;
    valid_i = 1'b1;
    foreach (words[i])
    begin
      @(negedge clk_i);
      data_i = words[i];
    end
    @(negedge clk_i);
    valid_i = 1'b0;
    data_i = '0;
    repeat (4) @(negedge clk_i); // two stage latency plus margin.
    if (got_q.size() != exp_q.size())
    begin
      $display("ERR beat_count got %h exp %h (dt %h wc %0d)", got_q.size(), exp_q.size(),
               dt, wc);
      err_cnt++;
    end
    else
      foreach (exp_q[i])
        if (got_q[i] !== exp_q[i])
        begin
          $display("ERR pkt_o beat %0d got %h exp %h", i, got_q[i], exp_q[i]);
          err_cnt++;
        end
    if (check_phy && phy_cnt != 1)
    begin
      $display("ERR phy_rst_o cycles got %h exp %h", phy_cnt, 1);
      err_cnt++;
    end
  endtask

  task automatic test_short();
    frame_packet(6'(rand_bits(3)), int'(rand_bits(16)), -1, -1, 1'b1, 1'b1);
  endtask

  task automatic test_long();
    for (int wc = 0; wc < 10; wc++)
      frame_packet(6'h2A, wc, -1, -1, 1'b1, 1'b1);
    for (int k = 0; k < 4; k++)
      frame_packet(6'h2B, int'(rand_bits(7)), -1, -1, 1'b1, 1'b1);
  endtask

  task automatic test_single_err();
    for (int k = 0; k < 6; k++)
      frame_packet(6'h2A, int'(rand_bits(4)), int'(rand_bits(5)) % 24, -1, 1'b1, 1'b1);
    for (int k = 0; k < 3; k++)
      frame_packet(6'h01, 5, 24 + int'(rand_bits(3)) % 6, -1, 1'b1, 1'b1);
  endtask

  task automatic test_fatal_err();
    frame_packet(6'h2A, 12, 0, 1, 1'b1, 1'b1);
    frame_packet(6'h2A, 7, -1, -1, 1'b1, 1'b1);
    frame_packet(6'h00, 3, 10, 27, 1'b1, 1'b1);
    frame_packet(6'h01, 4, -1, -1, 1'b1, 1'b1);
  endtask

  task automatic test_enable();
    fork
      frame_packet(6'h2B, 20, -1, -1, 1'b1, 1'b0);
      begin
        repeat (3) @(negedge clk_i);
        csr_write(ADDR_CTRL, 32'd0);
      end
    join
    repeat (4)
    begin
      @(negedge clk_i);
      if (phy_rst_o !== 1'b1)
      begin
        $display("ERR phy_rst_o got %h exp %h", phy_rst_o, 1'b1);
        err_cnt++;
      end
    end
    frame_packet(6'h00, 9, -1, -1, 1'b0, 1'b0);
    frame_packet(6'h2A, 8, -1, -1, 1'b0, 1'b0);
    csr_write(ADDR_CTRL, 32'd1);
    repeat (4) @(negedge clk_i);
    if (phy_rst_o !== 1'b0)
    begin
      $display("ERR phy_rst_o got %h exp %h", phy_rst_o, 1'b0);
      err_cnt++;
    end
    frame_packet(6'h02, 11, -1, -1, 1'b1, 1'b1);
    frame_packet(6'h2A, 6, -1, -1, 1'b1, 1'b1);
  endtask

  task automatic test_counters();
    csr_check(ADDR_CNT_SHORT, 32'(exp_short), "cnt_short");
    csr_check(ADDR_CNT_LONG, 32'(exp_long), "cnt_long");
    csr_check(ADDR_CNT_FIXED, 32'(exp_fixed), "cnt_fixed");
    csr_check(ADDR_CNT_FATAL, 32'(exp_fatal), "cnt_fatal");
    csr_write(ADDR_CNT_SHORT, 32'hFFFF_FFFF);
    csr_write(ADDR_CNT_LONG, 32'd0);
    csr_write(ADDR_CNT_FIXED, 32'd5);
    csr_write(ADDR_CNT_FATAL, 32'd1);
    csr_check(ADDR_CNT_SHORT, 32'd0, "cnt_short");
    csr_check(ADDR_CNT_LONG, 32'd0, "cnt_long");
    csr_check(ADDR_CNT_FIXED, 32'd0, "cnt_fixed");
    csr_check(ADDR_CNT_FATAL, 32'd0, "cnt_fatal");
    csr_check(8'h40, 32'd0, "unknown_addr");
  endtask

  initial
  begin
    #(WATCHDOG_NS * 1ns);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  initial
  begin
    data_i = '0;
    valid_i = 1'b0;
    csr_i = '0;
    lfsr_q = SEED;
    err_cnt = 0;
    phy_cnt = 0;
    exp_short = 0;
    exp_long = 0;
    exp_fixed = 0;
    exp_fatal = 0;
    @(negedge rst_i);
    csr_write(ADDR_CTRL, 32'd1);
    repeat (4) @(negedge clk_i); // enable passes one register before the framer.
    test_short();
    test_long();
    test_single_err();
    test_fatal_err();
    test_enable();
    test_counters();
    $display("errors: %0d", err_cnt);
    if (err_cnt == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
